//--- vstu_cfg.svh
////////////////////////////////////////////////////////////
// Vector store unit configuration
// Lane count, operand width, queue depth and id space
////////////////////////////////////////////////////////////

`ifndef VSTU_CFG_SVH
`define VSTU_CFG_SVH

// Number of lanes feeding the store unit
`define VSTU_NR_LANES 2

// Bits per lane operand
`define VSTU_ELEN 64

// Store instructions that may be in flight at once
`define VSTU_QUEUE_DEPTH 4

// Size of the instruction id space
`define VSTU_NR_VINSN 8

// Bits of the vector length field
`define VSTU_VL_WIDTH 9

`endif

//--- vstu_pkg.sv
////////////////////////////////////////////////////////////
// Vector store unit types shared by all blocks
////////////////////////////////////////////////////////////

`default_nettype none

`include "vstu_cfg.svh"

package vstu_pkg;

  // Bytes in one W beat, all lanes side by side
  localparam int unsigned BEAT_BYTES = `VSTU_NR_LANES * `VSTU_ELEN / 8;

  // Target functional unit of a sequencer request
  typedef enum logic [1:0] {
    VFU_STORE_UNIT = 2'd0,
    VFU_LOAD_UNIT  = 2'd1,
    VFU_ALU        = 2'd2,
    VFU_OTHER      = 2'd3
  } vfu_e;

  typedef logic [$clog2(`VSTU_NR_VINSN)-1:0] vinsn_id_t;

  // Element width code, bytes = 1 << code
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  typedef struct packed {
    vinsn_id_t                 id;
    vfu_e                      vfu;
    logic [`VSTU_VL_WIDTH-1:0] vl;
    vsew_e                     vsew;
  } pe_req_t;

  // Room for vl times 8 bytes
  typedef logic [`VSTU_VL_WIDTH+2:0] byte_cnt_t;

  typedef struct packed {
    vinsn_id_t id;
    byte_cnt_t bytes;
  } store_insn_t;

  typedef logic [`VSTU_ELEN-1:0]     elen_t;
  typedef logic [BEAT_BYTES*8-1:0]   beat_data_t;
  typedef logic [BEAT_BYTES-1:0]     beat_strb_t;
  typedef logic [7:0]                burst_len_t;

  typedef struct packed {
    logic [`VSTU_NR_VINSN-1:0] vinsn_done;
  } pe_resp_t;

endpackage

`default_nettype wire

//--- vstu_fifo.sv
////////////////////////////////////////////////////////////
// Small circular queue with a generic payload
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vstu_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4
) (
  input  wire  clk_i,
  input  wire  rst_ni,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic valid_o,
  output logic full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Storage has no reset, only the pointers matter
  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push, do_pop;

  assign valid_o = (count_q != '0);
  assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
  // Head shown without a register stage
  assign data_o  = mem_q[rd_ptr_q];

  // Drop a push on full and a pop on empty
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      count_q <= count_q + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
    end
  end

endmodule

`default_nettype wire

//--- vstu_decode.sv
////////////////////////////////////////////////////////////
// Store request decode
// Filters sequencer requests and queues them for issue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vstu_cfg.svh"

module vstu_decode import vstu_pkg::*; (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  pe_req_t                   pe_req_i,
  input  logic                      pe_req_valid_i,
  input  logic [`VSTU_NR_VINSN-1:0] pe_vinsn_running_i,
  output logic                      pe_req_ready_o,
  output store_insn_t               insn_o,
  output logic                      insn_valid_o,
  input  logic                      insn_pop_i,
  input  logic                      commit_i,
  output logic                      store_pending_o
);

  localparam int unsigned CNT_W = $clog2(`VSTU_QUEUE_DEPTH + 1);

  logic [`VSTU_NR_VINSN-1:0] running_q;
  logic [CNT_W-1:0]          inflight_q;
  logic                      accept;
  // Accepted request, one cycle before it enters the queue
  store_insn_t               stage_insn_q;
  logic                      stage_valid_q;

  assign pe_req_ready_o  = (inflight_q < CNT_W'(`VSTU_QUEUE_DEPTH));
  assign store_pending_o = (inflight_q != '0);

  // Only store-unit requests whose id has retired upstream
  assign accept = pe_req_valid_i && pe_req_ready_o &&
                  (pe_req_i.vfu == VFU_STORE_UNIT) && !running_q[pe_req_i.id];

  ////////////////////////////////////////////////////////////
  // Running ids and in-flight count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q     <= '0;
      inflight_q    <= '0;
      stage_valid_q <= 1'b0;
    end else begin
      // Sequencer clears ids as they finish everywhere
      running_q <= (running_q & pe_vinsn_running_i) |
                   ((`VSTU_NR_VINSN)'(accept) << pe_req_i.id);
      inflight_q    <= inflight_q + CNT_W'(accept) - CNT_W'(commit_i);
      stage_valid_q <= accept;
    end
  end

  // Byte count is vl scaled by the element width
  always_ff @(posedge clk_i) begin
    if (accept) begin
      stage_insn_q.id    <= pe_req_i.id;
      stage_insn_q.bytes <= byte_cnt_t'(pe_req_i.vl) << pe_req_i.vsew;
    end
  end

  // Issue queue
  vstu_fifo #(
    .T     (store_insn_t),
    .DEPTH (`VSTU_QUEUE_DEPTH)
  ) i_issue_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (stage_valid_q),
    .data_i  (stage_insn_q),
    .pop_i   (insn_pop_i),
    .data_o  (insn_o),
    .valid_o (insn_valid_o),
    .full_o  ()
  );

endmodule

`default_nettype wire

//--- vstu_execute.sv
////////////////////////////////////////////////////////////
// Store execute stage
// Packs lane operands into W beats and tracks bursts
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vstu_cfg.svh"

module vstu_execute import vstu_pkg::*; (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  // Issue queue head
  input  store_insn_t               insn_i,
  input  logic                      insn_valid_i,
  output logic                      insn_pop_o,
  // Address generator
  input  burst_len_t                burst_len_i,
  input  logic                      burst_valid_i,
  output logic                      burst_ready_o,
  // Lanes
  input  elen_t [`VSTU_NR_LANES-1:0] lane_operand_i,
  input  logic  [`VSTU_NR_LANES-1:0] lane_operand_valid_i,
  output logic  [`VSTU_NR_LANES-1:0] lane_operand_ready_o,
  // W channel
  output beat_data_t                w_data_o,
  output beat_strb_t                w_strb_o,
  output logic                      w_last_o,
  output logic                      w_valid_o,
  input  logic                      w_ready_i,
  // Finished instruction to the commit queue
  output vinsn_id_t                 done_id_o,
  output logic                      done_valid_o
);

  // Bytes already sent for the head instruction
  byte_cnt_t  sent_q;
  // Beats already sent in the current burst
  burst_len_t beat_cnt_q;
  byte_cnt_t  remaining;
  logic       fire;
  logic       insn_end;

  assign remaining = insn_i.bytes - sent_q;

  // Head, burst, all lanes and the W sink must line up
  assign fire = insn_valid_i && burst_valid_i && (&lane_operand_valid_i) && w_ready_i;

  assign w_valid_o            = fire;
  assign lane_operand_ready_o = {`VSTU_NR_LANES{fire}};

  // Burst ends when the beat count reaches the length code
  assign w_last_o      = fire && (beat_cnt_q == burst_len_i);
  assign burst_ready_o = w_last_o;

  // Final beat of the instruction
  assign insn_end     = fire && (remaining <= byte_cnt_t'(BEAT_BYTES));
  assign insn_pop_o   = insn_end;
  assign done_valid_o = insn_end;
  assign done_id_o    = insn_i.id;

  ////////////////////////////////////////////////////////////
  // Beat packing
  ////////////////////////////////////////////////////////////

  // Lane bytes are laid out in order, lane 0 in the low bytes
  always_comb begin
    w_data_o = '0;
    w_strb_o = '0;
    if (fire) begin
      for (int unsigned k = 0; k < BEAT_BYTES; k++) begin
        // Only bytes still owed by the instruction are written
        if (byte_cnt_t'(k) < remaining) begin
          w_data_o[8*k +: 8] = lane_operand_i[k/8][8*(k%8) +: 8];
          w_strb_o[k]        = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sent_q     <= '0;
      beat_cnt_q <= '0;
    end else if (fire) begin
      // Restart byte count for the next head
      if (insn_end) begin
        sent_q <= '0;
      end else begin
        sent_q <= sent_q + byte_cnt_t'(BEAT_BYTES);
      end
      if (w_last_o) begin
        beat_cnt_q <= '0;
      end else begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- vstu_result.sv
////////////////////////////////////////////////////////////
// Store commit stage, retires ids on B responses
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vstu_cfg.svh"

module vstu_result import vstu_pkg::*; (
  input  wire       clk_i,
  input  wire       rst_ni,
  input  vinsn_id_t done_id_i,
  input  logic      done_valid_i,
  input  logic      b_valid_i,
  output logic      b_ready_o,
  output logic      commit_o,
  output logic      store_complete_o,
  output pe_resp_t  pe_resp_o
);

  vinsn_id_t head_id;
  logic      head_valid;
  pe_resp_t  resp_d;

  // Every B beat is taken, even with nothing to retire
  assign b_ready_o        = b_valid_i;
  assign commit_o         = b_valid_i && head_valid;
  assign store_complete_o = commit_o;

  // One-hot done bit for the oldest id
  always_comb begin
    resp_d                     = '0;
    resp_d.vinsn_done[head_id] = commit_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_resp_o <= '0;
    end else begin
      pe_resp_o <= resp_d;
    end
  end

  // Ids in beat order, waiting for their B response
  vstu_fifo #(
    .T     (vinsn_id_t),
    .DEPTH (`VSTU_QUEUE_DEPTH)
  ) i_commit_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (done_valid_i),
    .data_i  (done_id_i),
    .pop_i   (commit_o),
    .data_o  (head_id),
    .valid_o (head_valid),
    .full_o  ()
  );

endmodule

`default_nettype wire

//--- vstu_top.sv
////////////////////////////////////////////////////////////
// Vector store unit top level
// Decode, execute and commit stages
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vstu_cfg.svh"

module vstu_top import vstu_pkg::*; (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  // Sequencer
  input  pe_req_t                    pe_req_i,
  input  logic                       pe_req_valid_i,
  input  logic [`VSTU_NR_VINSN-1:0]  pe_vinsn_running_i,
  output logic                       pe_req_ready_o,
  output pe_resp_t                   pe_resp_o,
  // Address generator
  input  burst_len_t                 burst_len_i,
  input  logic                       burst_valid_i,
  output logic                       burst_ready_o,
  // Lanes
  input  elen_t [`VSTU_NR_LANES-1:0] lane_operand_i,
  input  logic  [`VSTU_NR_LANES-1:0] lane_operand_valid_i,
  output logic  [`VSTU_NR_LANES-1:0] lane_operand_ready_o,
  // Memory W and B channels
  output beat_data_t                 w_data_o,
  output beat_strb_t                 w_strb_o,
  output logic                       w_last_o,
  output logic                       w_valid_o,
  input  logic                       w_ready_i,
  input  logic                       b_valid_i,
  output logic                       b_ready_o,
  // Dispatcher status
  output logic                       store_complete_o,
  output logic                       store_pending_o
);

  store_insn_t insn;
  logic        insn_valid, insn_pop;
  vinsn_id_t   done_id;
  logic        done_valid;
  logic        commit;

  vstu_decode i_decode (
    .clk_i, .rst_ni, .pe_req_i, .pe_req_valid_i, .pe_vinsn_running_i, .pe_req_ready_o,
    .insn_o (insn), .insn_valid_o (insn_valid), .insn_pop_i (insn_pop),
    .commit_i (commit), .store_pending_o
  );

  vstu_execute i_execute (
    .clk_i, .rst_ni,
    .insn_i (insn), .insn_valid_i (insn_valid), .insn_pop_o (insn_pop),
    .burst_len_i, .burst_valid_i, .burst_ready_o,
    .lane_operand_i, .lane_operand_valid_i, .lane_operand_ready_o,
    .w_data_o, .w_strb_o, .w_last_o, .w_valid_o, .w_ready_i,
    .done_id_o (done_id), .done_valid_o (done_valid)
  );

  vstu_result i_result (
    .clk_i, .rst_ni,
    .done_id_i (done_id), .done_valid_i (done_valid),
    .b_valid_i, .b_ready_o, .commit_o (commit), .store_complete_o, .pe_resp_o
  );

endmodule

`default_nettype wire

//--- vstu_tb.sv
////////////////////////////////////////////////////////////
// Vector store unit testbench
// Drives requests, lanes, bursts and B, checks against a model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vstu_cfg.svh"

module vstu_tb import vstu_pkg::*; ();

  // Longest run of all five tests with stalls, plus margin
  localparam int MAX_CYCLES = 2000;

  logic                               clk_i = 1'b0;
  logic                               rst_n;
  pe_req_t                            pe_req;
  logic                               pe_req_valid;
  logic [`VSTU_NR_VINSN-1:0]          pe_vinsn_running;
  burst_len_t                         burst_len;
  logic                               burst_valid;
  elen_t [`VSTU_NR_LANES-1:0]         lane_operand;
  logic  [`VSTU_NR_LANES-1:0]         lane_operand_valid;
  logic                               w_ready;
  logic                               b_valid;
  logic                               pe_req_ready_o, burst_ready_o, w_last_o, w_valid_o;
  logic                               b_ready_o, store_complete_o, store_pending_o;
  logic  [`VSTU_NR_LANES-1:0]         lane_operand_ready_o;
  pe_resp_t                           pe_resp_o;
  beat_data_t                         w_data_o;
  beat_strb_t                         w_strb_o;

  // Stimulus state
  logic [31:0] rng = 32'h6c91;
  elen_t       lane_words [64];
  int          beat_idx = 0;
  logic        stall_en = 1'b0;
  logic        beat_seen = 1'b0;
  logic        last_seen = 1'b0;
  burst_len_t  burst_q [$];

  // Model state
  vinsn_id_t   exp_ids [$];
  int          exp_bytes [$];
  vinsn_id_t   exp_done [$];
  logic        st1_v = 1'b0, st2_v = 1'b0;
  vinsn_id_t   st1_id, st2_id;
  int          st1_bytes, st2_bytes;
  logic [`VSTU_NR_VINSN-1:0] running_ref = '0;
  int          inflight = 0;
  int          sent_ref = 0;
  int          beat_cnt_ref = 0;
  pe_resp_t    resp_ref = '0;
  beat_data_t  log_data [$], ref_data [$];
  beat_strb_t  log_strb [$], ref_strb [$];
  beat_data_t  exp_beat_data;
  beat_strb_t  exp_beat_strb;

  int errors = 0, checks = 0, cycles = 0, test_num = 0, err_mark = 0;

  vstu_top uut (
    .clk_i, .rst_ni (rst_n), .pe_req_i (pe_req), .pe_req_valid_i (pe_req_valid),
    .pe_vinsn_running_i (pe_vinsn_running), .pe_req_ready_o, .pe_resp_o,
    .burst_len_i (burst_len), .burst_valid_i (burst_valid), .burst_ready_o,
    .lane_operand_i (lane_operand), .lane_operand_valid_i (lane_operand_valid),
    .lane_operand_ready_o, .w_data_o, .w_strb_o, .w_last_o, .w_valid_o,
    .w_ready_i (w_ready), .b_valid_i (b_valid), .b_ready_o, .store_complete_o,
    .store_pending_o
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Lanes concatenated in order, bytes past the end are not owed
  function automatic void ref_beat(input elen_t [`VSTU_NR_LANES-1:0] lanes, input int rem,
                                   output beat_data_t data, output beat_strb_t strb);
    data = beat_data_t'(lanes);
    strb = '0;
    for (int k = 0; k < BEAT_BYTES; k++) begin
      if (k < rem) begin
        strb[k] = 1'b1;
      end else begin
        data[8*k +: 8] = 8'h00;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_beat(input beat_data_t got_d, input beat_strb_t got_s,
                            input beat_data_t exp_d, input beat_strb_t exp_s);
    checks++;
    if (got_d !== exp_d || got_s !== exp_s) begin
      errors++;
      $display("CHECK FAILED at %0t: w_data_o/w_strb_o got %h/%h expected %h/%h",
               $time, got_d, got_s, exp_d, exp_s);
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: w_last_o got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_done(input pe_resp_t got, input pe_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: pe_resp_o got %b expected %b", $time, got, exp);
    end
  endtask

  // Single-bit status outputs
  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Lane and burst driver
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (beat_seen) begin
      beat_idx = beat_idx + 1;
    end
    if (last_seen && burst_q.size() != 0) begin
      burst_q.delete(0);
    end
    beat_seen = 1'b0;
    last_seen = 1'b0;
    rng = xorshift(rng);
    burst_valid        <= (burst_q.size() != 0);
    burst_len          <= (burst_q.size() != 0) ? burst_q[0] : '0;
    lane_operand       <= {lane_words[(2*beat_idx+1)%64], lane_words[(2*beat_idx)%64]};
    // About half the cycles stall when stalls are on
    lane_operand_valid <= stall_en ? {rng[5] | rng[6], rng[3] | rng[4]} : '1;
    w_ready            <= !stall_en || rng[1] || rng[2];
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Scoreboard, sampled at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : scoreboard
    logic       acc, fire_exp, last_exp, complete_exp;
    beat_data_t d;
    beat_strb_t s;
    int         rem;
    if (rst_n) begin
      // Accepted request reaches the issue head two edges later
      if (st2_v) begin
        exp_ids.push_back(st2_id);
        exp_bytes.push_back(st2_bytes);
      end
      st2_v = st1_v;
      st2_id = st1_id;
      st2_bytes = st1_bytes;
      check_flag("pe_req_ready_o", pe_req_ready_o, inflight < `VSTU_QUEUE_DEPTH);
      check_flag("store_pending_o", store_pending_o, inflight != 0);
      acc = pe_req_valid && (inflight < `VSTU_QUEUE_DEPTH) &&
            (pe_req.vfu == VFU_STORE_UNIT) && !running_ref[pe_req.id];
      st1_v = acc;
      st1_id = pe_req.id;
      st1_bytes = int'(pe_req.vl) << pe_req.vsew;
      running_ref = running_ref & pe_vinsn_running;
      if (acc) begin
        running_ref[pe_req.id] = 1'b1;
      end
      // W beat
      fire_exp = (exp_ids.size() != 0) && burst_valid && (&lane_operand_valid) && w_ready;
      last_exp = fire_exp && (beat_cnt_ref == int'(burst_len));
      check_flag("w_valid_o", w_valid_o, fire_exp);
      check_last(w_last_o, last_exp);
      check_flag("burst_ready_o", burst_ready_o, last_exp);
      for (int l = 0; l < `VSTU_NR_LANES; l++) begin
        check_flag("lane_operand_ready_o", lane_operand_ready_o[l], fire_exp);
      end
      if (fire_exp) begin
        rem = exp_bytes[0] - sent_ref;
        ref_beat(lane_operand, rem, d, s);
        check_beat(w_data_o, w_strb_o, d, s);
        log_data.push_back(w_data_o);
        log_strb.push_back(w_strb_o);
        beat_seen = 1'b1;
        last_seen = last_exp;
        beat_cnt_ref = last_exp ? 0 : beat_cnt_ref + 1;
        if (rem <= BEAT_BYTES) begin
          exp_done.push_back(exp_ids[0]);
          exp_ids.delete(0);
          exp_bytes.delete(0);
          sent_ref = 0;
        end else begin
          sent_ref = sent_ref + BEAT_BYTES;
        end
      end
      // B channel and the registered done response
      check_done(pe_resp_o, resp_ref);
      complete_exp = b_valid && (exp_done.size() != 0);
      check_flag("b_ready_o", b_ready_o, b_valid);
      check_flag("store_complete_o", store_complete_o, complete_exp);
      resp_ref = '0;
      if (complete_exp) begin
        resp_ref.vinsn_done[exp_done[0]] = 1'b1;
        exp_done.delete(0);
      end
      inflight = inflight + (acc ? 1 : 0) - (complete_exp ? 1 : 0);
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////

  // Leaves valid high so the next request can follow directly
  task automatic send_req(input vinsn_id_t id, input vfu_e vfu, input int vl,
                          input vsew_e sew);
    @(posedge clk_i);
    pe_req.id    <= id;
    pe_req.vfu   <= vfu;
    pe_req.vl    <= (`VSTU_VL_WIDTH)'(vl);
    pe_req.vsew  <= sew;
    pe_req_valid <= 1'b1;
    @(negedge clk_i);
    while (!pe_req_ready_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic drop_req();
    @(posedge clk_i);
    pe_req_valid <= 1'b0;
  endtask

  task automatic send_b();
    @(posedge clk_i);
    b_valid <= 1'b1;
    @(posedge clk_i);
    b_valid <= 1'b0;
    @(posedge clk_i);
  endtask

  // Until every queued instruction and burst has been sent
  task automatic wait_idle();
    do begin
      @(negedge clk_i);
    end while (st1_v || st2_v || exp_ids.size() != 0 || burst_q.size() != 0);
  endtask

  task automatic test_start();
    test_num++;
    err_mark = errors;
    log_data = {};
    log_strb = {};
  endtask

  task automatic test_end(input string name);
    $display("test %0d %s: %s", test_num, name, (errors == err_mark) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n              = 1'b0;
    pe_req             = '0;
    pe_req_valid       = 1'b0;
    pe_vinsn_running   = '0;
    burst_len          = '0;
    burst_valid        = 1'b0;
    lane_operand       = '0;
    lane_operand_valid = '0;
    w_ready            = 1'b0;
    b_valid            = 1'b0;
    for (int i = 0; i < 64; i++) begin
      rng = xorshift(rng);
      lane_words[i][31:0] = rng;
      rng = xorshift(rng);
      lane_words[i][63:32] = rng;
    end
    repeat (3) @(posedge clk_i);
    rst_n <= 1'b1;

    // 40 bytes in one 3-beat burst
    test_start();
    beat_idx = 0;
    send_req(3'd1, VFU_STORE_UNIT, 5, EW64);
    drop_req();
    burst_q.push_back(8'd2);
    wait_idle();
    if (log_data.size() != 3) begin
      errors++;
      $display("single store sent %0d beats instead of 3", log_data.size());
    end
    // Expected beats of the unstalled run, 40 bytes from lane words 0 to 5
    ref_data = {};
    ref_strb = {};
    for (int i = 0; i < 3; i++) begin
      ref_beat({lane_words[2*i+1], lane_words[2*i]}, 40 - 16*i, exp_beat_data, exp_beat_strb);
      ref_data.push_back(exp_beat_data);
      ref_strb.push_back(exp_beat_strb);
    end
    send_b();
    test_end("single store");

    // Same store again with random stalls
    test_start();
    beat_idx = 0;
    stall_en = 1'b1;
    send_req(3'd2, VFU_STORE_UNIT, 5, EW64);
    drop_req();
    burst_q.push_back(8'd2);
    wait_idle();
    stall_en = 1'b0;
    if (log_data.size() != ref_data.size()) begin
      errors++;
      $display("stalled run sent %0d beats, unstalled run %0d",
               log_data.size(), ref_data.size());
    end else begin
      for (int i = 0; i < log_data.size(); i++) begin
        check_beat(log_data[i], log_strb[i], ref_data[i], ref_strb[i]);
      end
    end
    send_b();
    test_end("stalls");

    // Four stores fill the queue, one burst each
    test_start();
    send_req(3'd3, VFU_STORE_UNIT, 20, EW8);
    send_req(3'd4, VFU_STORE_UNIT, 12, EW16);
    send_req(3'd5, VFU_STORE_UNIT, 9, EW32);
    send_req(3'd0, VFU_STORE_UNIT, 2, EW64);
    drop_req();
    @(negedge clk_i);
    check_flag("pe_req_ready_o", pe_req_ready_o, 1'b0);
    burst_q.push_back(8'd1);
    burst_q.push_back(8'd1);
    burst_q.push_back(8'd2);
    burst_q.push_back(8'd0);
    wait_idle();
    send_b();
    @(negedge clk_i);
    check_flag("pe_req_ready_o", pe_req_ready_o, 1'b1);
    test_end("full queue");

    // Retire the rest in order, then one B with nothing queued
    test_start();
    send_b();
    send_b();
    send_b();
    @(negedge clk_i);
    check_flag("store_pending_o", store_pending_o, 1'b0);
    send_b();
    test_end("commit order");

    // Wrong unit, then an id still marked running
    test_start();
    send_req(3'd7, VFU_ALU, 4, EW8);
    drop_req();
    @(posedge clk_i);
    pe_vinsn_running <= 8'h40;
    send_req(3'd6, VFU_STORE_UNIT, 1, EW8);
    drop_req();
    burst_q.push_back(8'd0);
    wait_idle();
    send_b();
    send_req(3'd6, VFU_STORE_UNIT, 3, EW8);
    drop_req();
    burst_q.push_back(8'd0);
    repeat (20) @(negedge clk_i);
    if (log_data.size() != 1) begin
      errors++;
      $display("filtered requests produced %0d beats", log_data.size() - 1);
    end
    check_flag("store_pending_o", store_pending_o, 1'b0);
    burst_q = {};
    @(posedge clk_i);
    pe_vinsn_running <= '0;
    repeat (3) @(negedge clk_i);
    test_end("request filter");

    $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
vstu_pkg.sv
vstu_fifo.sv
vstu_decode.sv
vstu_execute.sv
vstu_result.sv
vstu_top.sv
vstu_tb.sv
